// File: rtl/mips_consts.svh
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// ==================================================
// Word and register file geometry
// ==================================================
`define MIPS_DATA_W      32
`define MIPS_REG_ADDR_W  5
`define MIPS_NUM_REGS    32

// ==================================================
// Program counter
// ==================================================
`define MIPS_RESET_PC    32'h0000_0000
`define MIPS_PC_STEP     32'd4

// Shift-add iterations for multu
`define MIPS_MULT_STEPS  32

`endif

// File: rtl/mips_pkg.sv
package mips_pkg;

   // ==================================================
   // Controller states
   // ==================================================
   typedef enum logic [4:0] {
      StReset, StFetch1, StFetch2, StFetch3, StDecode,
      StExAluR, StAluI,
      StLw1, StLw2, StLw3, StLw4, StLw5,
      StSw1, StSw2, StSw3,
      StBra1, StBra2,
      StMultu1, StMultu2, StMoveFrom,
      StJump
   } stateT;

   // Primary opcode field
   typedef enum logic [5:0] {
      OpSpecial = 6'h00, OpJ     = 6'h02, OpBeq   = 6'h04, OpBne  = 6'h05,
      OpAddi    = 6'h08, OpAddiu = 6'h09, OpSlti  = 6'h0a, OpSltiu = 6'h0b,
      OpAndi    = 6'h0c, OpOri   = 6'h0d, OpXori  = 6'h0e, OpLui  = 6'h0f,
      OpLw      = 6'h23, OpSw    = 6'h2b
   } opcodeT;

   // Funct field of Special
   typedef enum logic [5:0] {
      FnMfhi = 6'h10, FnMflo = 6'h12, FnMultu = 6'h19,
      FnAdd  = 6'h20, FnAddu = 6'h21, FnSub   = 6'h22, FnSubu = 6'h23,
      FnAnd  = 6'h24, FnOr   = 6'h25, FnXor   = 6'h26, FnNor  = 6'h27,
      FnSlt  = 6'h2a, FnSltu = 6'h2b
   } functT;

   typedef enum logic [3:0] {
      AluAdd  = 4'h0, AluSub  = 4'h1, AluSlt = 4'h2, AluSltu = 4'h3,
      AluAnd  = 4'h4, AluOr   = 4'h5, AluXor = 4'h6, AluNor  = 4'h7,
      AluAddu = 4'h8, AluSubu = 4'h9, AluLui = 4'hb
   } aluOpT;

   // ==================================================
   // Datapath mux selects
   // ==================================================
   typedef enum logic {PcFromAlu, PcFromJump} pcSrcT;

   typedef enum logic [1:0] {AddrPc, AddrAlu, AddrJump} addrSrcT;

   typedef enum logic [1:0] {BRegB, BFour, BImm, BImmShifted} aluBSelT;

   typedef enum logic {DstRt, DstRd} regDstT;

   typedef enum logic [1:0] {WbAlu, WbMem, WbLo, WbHi} wbSrcT;

endpackage

// File: rtl/mipsAlu.sv
`timescale 1ns/1ps
`include "mips_consts.svh"

module mipsAlu (
   input  logic [`MIPS_DATA_W-1:0] a,
   input  logic [`MIPS_DATA_W-1:0] b,
   input  mips_pkg::aluOpT         op,
   output logic [`MIPS_DATA_W-1:0] result,
   output logic                    zero
);

   localparam int Msb = `MIPS_DATA_W - 1;

   logic            isSub, overflow, lessSigned, lessUnsigned;
   logic [Msb:0]    bIn;
   logic [Msb+1:0]  sum;

   // One adder for add, sub and both compares
   assign isSub = (op == mips_pkg::AluSub) || (op == mips_pkg::AluSubu) ||
                  (op == mips_pkg::AluSlt) || (op == mips_pkg::AluSltu);
   assign bIn = isSub ? ~b : b;
   assign sum = {1'b0, a} + {1'b0, bIn} + {{Msb+1{1'b0}}, isSub};

   assign overflow     = (a[Msb] != b[Msb]) && (a[Msb] != sum[Msb]);
   assign lessSigned   = overflow ^ sum[Msb];
   assign lessUnsigned = ~sum[Msb+1];   // No carry out means borrow

   always_comb begin
      case (op)
         mips_pkg::AluAdd, mips_pkg::AluAddu,
         mips_pkg::AluSub, mips_pkg::AluSubu: result = sum[Msb:0];
         mips_pkg::AluSlt:  result = {{Msb{1'b0}}, lessSigned};
         mips_pkg::AluSltu: result = {{Msb{1'b0}}, lessUnsigned};
         mips_pkg::AluAnd:  result = a & b;
         mips_pkg::AluOr:   result = a | b;
         mips_pkg::AluXor:  result = a ^ b;
         mips_pkg::AluNor:  result = ~(a | b);
         mips_pkg::AluLui:  result = b << 16;
         default:           result = '0;
      endcase
   end

   assign zero = (result == '0);

endmodule

// File: rtl/regFile.sv
`timescale 1ns/1ps
`include "mips_consts.svh"

module regFile (
   input  logic                        clk,
   input  logic                        write,
   input  logic [`MIPS_REG_ADDR_W-1:0] readAddr1,
   input  logic [`MIPS_REG_ADDR_W-1:0] readAddr2,
   input  logic [`MIPS_REG_ADDR_W-1:0] writeAddr,
   input  logic [`MIPS_DATA_W-1:0]     writeData,
   output logic [`MIPS_DATA_W-1:0]     readData1,
   output logic [`MIPS_DATA_W-1:0]     readData2
);

   logic [`MIPS_DATA_W-1:0] regs [`MIPS_NUM_REGS];

   always_ff @(posedge clk) begin
      if (write && writeAddr != '0)
         regs[writeAddr] <= writeData;
   end

   // Register 0 is hardwired
   assign readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
   assign readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];

   // Index comes from the IR held in the datapath
   wrAddrKnown: assert property (@(posedge clk) write |-> !$isunknown(writeAddr));

endmodule

// File: rtl/multuUnit.sv
`timescale 1ns/1ps
`include "mips_consts.svh"

module multuUnit (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      start,
   input  logic [`MIPS_DATA_W-1:0]   multiplicand,
   input  logic [`MIPS_DATA_W-1:0]   multiplier,
   output logic [2*`MIPS_DATA_W-1:0] product,
   output logic                      ready
);

   localparam int CntW = $clog2(`MIPS_MULT_STEPS) + 1;

   logic [CntW-1:0]          count;
   logic [`MIPS_DATA_W:0]    partial;   // 33-bit sum with carry

   assign ready = count[CntW-1];
   assign partial = {1'b0, product[2*`MIPS_DATA_W-1:`MIPS_DATA_W]} +
                    {1'b0, product[0] ? multiplicand : {`MIPS_DATA_W{1'b0}}};

   always_ff @(posedge clk) begin
      if (reset) begin
         count <= CntW'(`MIPS_MULT_STEPS);   // Idle and done
      end else if (start) begin
         count <= '0;
      end else if (!ready) begin
         count <= count + 1'b1;
      end
   end

   // ==================================================
   // Shift-add step
   // ==================================================
   always_ff @(posedge clk) begin
      if (start)
         product <= {{`MIPS_DATA_W{1'b0}}, multiplier};
      else if (!ready)
         product <= {partial, product[`MIPS_DATA_W-1:1]};
   end

endmodule

// File: rtl/mipsControl.sv
`timescale 1ns/1ps

module mipsControl (
   input  logic              clk,
   input  logic              reset,
   input  mips_pkg::opcodeT  opcode,
   input  mips_pkg::functT   funct,
   input  logic              aluZero,
   input  logic              multReady,
   output logic              pcWrite,
   output logic              irWrite,
   output logic              abWrite,
   output logic              mdrWrite,
   output logic              marWrite,
   output logic              rfWrite,
   output logic              multStart,
   output logic              signExt,
   output logic              aluSelA,
   output logic              memRead,
   output logic              memWrite,
   output mips_pkg::pcSrcT   pcSrc,
   output mips_pkg::addrSrcT addrSrc,
   output mips_pkg::aluBSelT aluSelB,
   output mips_pkg::regDstT  regDst,
   output mips_pkg::wbSrcT   wbSrc,
   output mips_pkg::aluOpT   aluOp
);

   mips_pkg::stateT state, nextState;
   logic setMemRead, clrMemRead, setMemWrite, clrMemWrite;
   logic prepFetch;   // MAR <- PC and start the next fetch

   // ==================================================
   // State and memory strobe flops
   // ==================================================
   always_ff @(posedge clk) begin
      if (reset)
         state <= mips_pkg::StReset;
      else
         state <= nextState;
   end

   always_ff @(posedge clk) begin
      if (reset || clrMemRead)
         memRead <= 1'b0;
      else if (setMemRead)
         memRead <= 1'b1;
      if (reset || clrMemWrite)
         memWrite <= 1'b0;
      else if (setMemWrite)
         memWrite <= 1'b1;
   end

   // ==================================================
   // Next state and control lines
   // ==================================================
   always_comb begin
      nextState   = state;
      prepFetch   = 1'b0;
      pcWrite     = 1'b0;
      irWrite     = 1'b0;
      abWrite     = 1'b0;
      mdrWrite    = 1'b0;
      marWrite    = 1'b0;
      rfWrite     = 1'b0;
      multStart   = 1'b0;
      setMemRead  = 1'b0;
      clrMemRead  = 1'b0;
      setMemWrite = 1'b0;
      clrMemWrite = 1'b0;
      pcSrc       = mips_pkg::PcFromAlu;
      addrSrc     = mips_pkg::AddrPc;
      aluSelA     = 1'b1;
      aluSelB     = mips_pkg::BRegB;
      regDst      = mips_pkg::DstRt;
      wbSrc       = mips_pkg::WbAlu;
      aluOp       = mips_pkg::AluAdd;
      signExt     = 1'b1;

      case (state)
         mips_pkg::StFetch1: nextState = mips_pkg::StFetch2;
         mips_pkg::StFetch2: nextState = mips_pkg::StFetch3;
         mips_pkg::StFetch3: begin
            irWrite    = 1'b1;
            pcWrite    = 1'b1;   // PC + 4
            clrMemRead = 1'b1;
            aluSelA    = 1'b0;
            aluSelB    = mips_pkg::BFour;
            nextState  = mips_pkg::StDecode;
         end
         mips_pkg::StDecode: begin
            abWrite = 1'b1;
            case (opcode)
               mips_pkg::OpSpecial:
                  case (funct)
                     mips_pkg::FnMfhi, mips_pkg::FnMflo:
                        nextState = mips_pkg::StMoveFrom;
                     mips_pkg::FnMultu: nextState = mips_pkg::StMultu1;
                     mips_pkg::FnAdd, mips_pkg::FnAddu, mips_pkg::FnSub, mips_pkg::FnSubu,
                     mips_pkg::FnAnd, mips_pkg::FnOr, mips_pkg::FnXor, mips_pkg::FnNor,
                     mips_pkg::FnSlt, mips_pkg::FnSltu:
                        nextState = mips_pkg::StExAluR;
                     default: prepFetch = 1'b1;   // Unknown funct is a no-op
                  endcase
               // j needs only IR, so it finishes inside decode
               mips_pkg::OpJ: begin
                  pcWrite    = 1'b1;
                  pcSrc      = mips_pkg::PcFromJump;
                  addrSrc    = mips_pkg::AddrJump;
                  marWrite   = 1'b1;
                  setMemRead = 1'b1;
                  nextState  = mips_pkg::StFetch1;
               end
               mips_pkg::OpBeq, mips_pkg::OpBne: nextState = mips_pkg::StBra1;
               mips_pkg::OpLw: nextState = mips_pkg::StLw1;
               mips_pkg::OpSw: nextState = mips_pkg::StSw1;
               mips_pkg::OpAddi, mips_pkg::OpAddiu, mips_pkg::OpSlti, mips_pkg::OpSltiu,
               mips_pkg::OpAndi, mips_pkg::OpOri, mips_pkg::OpXori, mips_pkg::OpLui:
                  nextState = mips_pkg::StAluI;
               default: prepFetch = 1'b1;
            endcase
         end
         mips_pkg::StExAluR: begin
            regDst    = mips_pkg::DstRd;
            rfWrite   = 1'b1;
            prepFetch = 1'b1;
            case (funct)
               mips_pkg::FnAddu: aluOp = mips_pkg::AluAddu;
               mips_pkg::FnSub:  aluOp = mips_pkg::AluSub;
               mips_pkg::FnSubu: aluOp = mips_pkg::AluSubu;
               mips_pkg::FnAnd:  aluOp = mips_pkg::AluAnd;
               mips_pkg::FnOr:   aluOp = mips_pkg::AluOr;
               mips_pkg::FnXor:  aluOp = mips_pkg::AluXor;
               mips_pkg::FnNor:  aluOp = mips_pkg::AluNor;
               mips_pkg::FnSlt:  aluOp = mips_pkg::AluSlt;
               mips_pkg::FnSltu: aluOp = mips_pkg::AluSltu;
               default:          aluOp = mips_pkg::AluAdd;
            endcase
         end
         mips_pkg::StAluI: begin
            aluSelB   = mips_pkg::BImm;
            rfWrite   = 1'b1;
            prepFetch = 1'b1;
            signExt   = !(opcode inside {mips_pkg::OpAndi, mips_pkg::OpOri,
                                         mips_pkg::OpXori, mips_pkg::OpLui});
            case (opcode)
               mips_pkg::OpAddiu: aluOp = mips_pkg::AluAddu;
               mips_pkg::OpSlti:  aluOp = mips_pkg::AluSlt;
               mips_pkg::OpSltiu: aluOp = mips_pkg::AluSltu;
               mips_pkg::OpAndi:  aluOp = mips_pkg::AluAnd;
               mips_pkg::OpOri:   aluOp = mips_pkg::AluOr;
               mips_pkg::OpXori:  aluOp = mips_pkg::AluXor;
               mips_pkg::OpLui:   aluOp = mips_pkg::AluLui;
               default:           aluOp = mips_pkg::AluAdd;
            endcase
         end
         mips_pkg::StLw1, mips_pkg::StSw1: begin
            aluSelB  = mips_pkg::BImm;   // A + offset
            addrSrc  = mips_pkg::AddrAlu;
            marWrite = 1'b1;
            if (state == mips_pkg::StLw1) begin
               setMemRead = 1'b1;
               nextState  = mips_pkg::StLw2;
            end else begin
               nextState = mips_pkg::StSw2;
            end
         end
         mips_pkg::StLw2: nextState = mips_pkg::StLw3;
         mips_pkg::StLw3: nextState = mips_pkg::StLw4;
         mips_pkg::StLw4: begin
            mdrWrite   = 1'b1;
            clrMemRead = 1'b1;
            nextState  = mips_pkg::StLw5;
         end
         mips_pkg::StLw5: begin
            wbSrc     = mips_pkg::WbMem;
            rfWrite   = 1'b1;
            prepFetch = 1'b1;
         end
         mips_pkg::StSw2: begin
            setMemWrite = 1'b1;
            nextState   = mips_pkg::StSw3;
         end
         mips_pkg::StSw3: begin
            clrMemWrite = 1'b1;
            prepFetch   = 1'b1;
         end
         mips_pkg::StBra1: begin
            aluOp = mips_pkg::AluSub;
            if (aluZero ^ (opcode == mips_pkg::OpBne))
               nextState = mips_pkg::StBra2;
            else
               prepFetch = 1'b1;
         end
         mips_pkg::StBra2: begin
            aluSelA    = 1'b0;   // PC + 4 + (imm << 2)
            aluSelB    = mips_pkg::BImmShifted;
            pcWrite    = 1'b1;
            addrSrc    = mips_pkg::AddrAlu;
            marWrite   = 1'b1;
            setMemRead = 1'b1;
            nextState  = mips_pkg::StFetch1;
         end
         mips_pkg::StMultu1: begin
            multStart = 1'b1;
            nextState = mips_pkg::StMultu2;
         end
         mips_pkg::StMultu2: prepFetch = multReady;
         mips_pkg::StMoveFrom: begin
            regDst    = mips_pkg::DstRd;
            wbSrc     = (funct == mips_pkg::FnMfhi) ? mips_pkg::WbHi : mips_pkg::WbLo;
            rfWrite   = 1'b1;
            prepFetch = 1'b1;
         end
         default: prepFetch = 1'b1;   // Reset and any stray code
      endcase

      if (prepFetch) begin
         addrSrc    = mips_pkg::AddrPc;
         marWrite   = 1'b1;
         setMemRead = 1'b1;
         nextState  = mips_pkg::StFetch1;
      end
   end

   // Strobes come from separate set/clear paths
   memExclusive: assert property (@(posedge clk) disable iff (reset) !(memRead && memWrite));

   // Multiplier in datapath must finish within its step count
   multDone: assert property (@(posedge clk) disable iff (reset)
      multStart |-> ##[1:33] multReady);

endmodule

// File: rtl/mipsDatapath.sv
`timescale 1ns/1ps
`include "mips_consts.svh"

module mipsDatapath (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      pcWrite,
   input  logic                      irWrite,
   input  logic                      abWrite,
   input  logic                      mdrWrite,
   input  logic                      marWrite,
   input  logic                      rfWrite,
   input  logic                      multStart,
   input  logic                      signExt,
   input  logic                      aluSelA,
   input  mips_pkg::pcSrcT           pcSrc,
   input  mips_pkg::addrSrcT         addrSrc,
   input  mips_pkg::aluBSelT         aluSelB,
   input  mips_pkg::regDstT          regDst,
   input  mips_pkg::wbSrcT           wbSrc,
   input  mips_pkg::aluOpT           aluOp,
   input  logic [`MIPS_DATA_W-1:0]   memReadData,
   output mips_pkg::opcodeT          opcode,
   output mips_pkg::functT           funct,
   output logic                      aluZero,
   output logic                      multReady,
   output logic [`MIPS_DATA_W-1:0]   memAddr,
   output logic [`MIPS_DATA_W-1:0]   memWriteData
);

   logic [`MIPS_DATA_W-1:0] pc, ir, regA, regB, mdr, mar;
   logic [`MIPS_DATA_W-1:0] rfData1, rfData2, wbData, aluA, aluB, aluResult;
   logic [`MIPS_DATA_W-1:0] imm, jumpTarget, marNext;
   logic [2*`MIPS_DATA_W-1:0] product;
   logic [`MIPS_REG_ADDR_W-1:0] wbAddr;

   assign opcode       = mips_pkg::opcodeT'(ir[31:26]);
   assign funct        = mips_pkg::functT'(ir[5:0]);
   assign memAddr      = mar;
   assign memWriteData = regB;

   // ==================================================
   // Architectural and staging registers
   // ==================================================
   always_ff @(posedge clk) begin
      if (reset)
         pc <= `MIPS_RESET_PC;
      else if (pcWrite)
         pc <= (pcSrc == mips_pkg::PcFromJump) ? jumpTarget : aluResult;
   end

   always_ff @(posedge clk) begin
      if (irWrite) ir <= memReadData;
      if (mdrWrite) mdr <= memReadData;
      if (marWrite) mar <= marNext;
      if (abWrite) begin
         regA <= rfData1;
         regB <= rfData2;
      end
   end

   // ==================================================
   // Muxes and immediate handling
   // ==================================================
   assign jumpTarget = {pc[31:28], ir[25:0], 2'b00};
   assign imm = signExt ? {{16{ir[15]}}, ir[15:0]} : {16'h0000, ir[15:0]};
   assign aluA = aluSelA ? regA : pc;
   assign wbAddr = (regDst == mips_pkg::DstRd) ? ir[15:11] : ir[20:16];

   always_comb begin
      case (aluSelB)
         mips_pkg::BFour:       aluB = `MIPS_PC_STEP;
         mips_pkg::BImm:        aluB = imm;
         mips_pkg::BImmShifted: aluB = imm << 2;   // Branch word offset
         default:               aluB = regB;
      endcase
      case (addrSrc)
         mips_pkg::AddrAlu:  marNext = aluResult;
         mips_pkg::AddrJump: marNext = jumpTarget;
         default:            marNext = pc;
      endcase
      case (wbSrc)
         mips_pkg::WbMem: wbData = mdr;
         mips_pkg::WbLo:  wbData = product[`MIPS_DATA_W-1:0];
         mips_pkg::WbHi:  wbData = product[2*`MIPS_DATA_W-1:`MIPS_DATA_W];
         default:         wbData = aluResult;
      endcase
   end

   regFile rf (
      .clk, .write(rfWrite),
      .readAddr1(ir[25:21]), .readAddr2(ir[20:16]), .writeAddr(wbAddr),
      .writeData(wbData), .readData1(rfData1), .readData2(rfData2)
   );

   mipsAlu alu (.a(aluA), .b(aluB), .op(aluOp), .result(aluResult), .zero(aluZero));

   multuUnit mult (
      .clk, .reset, .start(multStart), .multiplicand(regA), .multiplier(regB),
      .product, .ready(multReady)
   );

endmodule

// File: rtl/multiCycleMips.sv
`timescale 1ns/1ps
`include "mips_consts.svh"

module multiCycleMips (
   input  logic                    clk,
   input  logic                    reset,
   input  logic [`MIPS_DATA_W-1:0] memReadData,
   output logic [`MIPS_DATA_W-1:0] memAddr,
   output logic [`MIPS_DATA_W-1:0] memWriteData,
   output logic                    memRead,
   output logic                    memWrite
);

   logic pcWrite, irWrite, abWrite, mdrWrite, marWrite, rfWrite;
   logic multStart, multReady, signExt, aluSelA, aluZero;
   mips_pkg::pcSrcT   pcSrc;
   mips_pkg::addrSrcT addrSrc;
   mips_pkg::aluBSelT aluSelB;
   mips_pkg::regDstT  regDst;
   mips_pkg::wbSrcT   wbSrc;
   mips_pkg::aluOpT   aluOp;
   mips_pkg::opcodeT  opcode;
   mips_pkg::functT   funct;

   mipsControl control (
      .clk, .reset, .opcode, .funct, .aluZero, .multReady,
      .pcWrite, .irWrite, .abWrite, .mdrWrite, .marWrite, .rfWrite,
      .multStart, .signExt, .aluSelA, .memRead, .memWrite,
      .pcSrc, .addrSrc, .aluSelB, .regDst, .wbSrc, .aluOp
   );

   mipsDatapath datapath (
      .clk, .reset,
      .pcWrite, .irWrite, .abWrite, .mdrWrite, .marWrite, .rfWrite,
      .multStart, .signExt, .aluSelA,
      .pcSrc, .addrSrc, .aluSelB, .regDst, .wbSrc, .aluOp,
      .memReadData,
      .opcode, .funct, .aluZero, .multReady, .memAddr, .memWriteData
   );

endmodule

// File: verif/tbClock.sv
`timescale 1ns/1ps

module tbClock (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;   // 8 ns period
   end

   // Released 1 ns after the eighth rising edge
   initial begin
      reset = 1'b1;
      repeat (8) @(posedge clk);
      #1 reset = 1'b0;
   end

endmodule

// File: verif/tbMemory.sv
`timescale 1ns/1ps
`include "mips_consts.svh"

module tbMemory (
   input  logic                    clk,
   input  logic [`MIPS_DATA_W-1:0] memAddr,
   input  logic [`MIPS_DATA_W-1:0] memWriteData,
   input  logic                    memRead,
   input  logic                    memWrite,
   output logic [`MIPS_DATA_W-1:0] memReadData,
   output logic                    storeValid,
   output logic [`MIPS_DATA_W-1:0] storeAddr,
   output logic [`MIPS_DATA_W-1:0] storeData
);

   localparam int Words = 1024;   // 4 KB

   logic [`MIPS_DATA_W-1:0] words [Words];

   initial begin
      memReadData = '0;
      storeValid  = 1'b0;
      storeAddr   = '0;
      storeData   = '0;
      for (int i = 0; i < Words; i++)
         words[i] = 32'hBAD0_0000 | (i << 2);   // Byte address in the low half
   end

   // Registered read and store monitor with outputs 1 ns after the edge
   always @(posedge clk) begin
      logic                    readNow, writeNow;
      logic [9:0]              index;
      logic [`MIPS_DATA_W-1:0] addrNow, dataNow;
      readNow  = memRead;
      writeNow = memWrite;
      addrNow  = memAddr;
      dataNow  = memWriteData;
      index    = addrNow[11:2];
      #1;
      if (readNow)
         memReadData = words[index];
      if (writeNow)
         words[index] = dataNow;
      storeValid = writeNow;
      storeAddr  = addrNow;
      storeData  = dataNow;
   end

endmodule

// File: verif/mipsTb.sv
`timescale 1ns/1ps

module mipsTb;

   localparam logic [31:0] OpndA      = 32'h8000_0005;   // Negative operand
   localparam logic [31:0] OpndB      = 32'h7FFF_FFF4;
   localparam int          DataBase   = 'h800;
   localparam int          ResultBase = 'hC00;
   localparam int          MarkerAddr = 'hFFC;
   localparam int          NumWords   = 4;
   localparam int          NumMults   = 3;

   logic        clk, reset, memRead, memWrite, storeValid;
   logic [31:0] memAddr, memWriteData, memReadData, storeAddr, storeData;

   logic [31:0] prog[$];
   logic [31:0] expAddr[$];
   logic [31:0] expData[$];
   logic [31:0] dataWords[NumWords];
   logic [31:0] multA[NumMults];
   logic [31:0] multB[NumMults];
   int          resultPtr;
   int          watchdogNs;

   tbClock clock (.clk, .reset);

   multiCycleMips uut (
      .clk, .reset, .memReadData, .memAddr, .memWriteData, .memRead, .memWrite
   );

   tbMemory memory (
      .clk, .memAddr, .memWriteData, .memRead, .memWrite,
      .memReadData, .storeValid, .storeAddr, .storeData
   );

   task automatic stopWithFailure();
      $display("Test FAILED");
      $fatal(1);
   endtask

   task automatic reportMismatch(string name, logic [31:0] got, logic [31:0] want);
      $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got, want);
      stopWithFailure();
   endtask

   // ==================================================
   // Instruction encoding
   // ==================================================
   function automatic logic [31:0] rWord(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                         mips_pkg::functT fn);
      return {6'h00, rs, rt, rd, 5'h00, fn};
   endfunction

   function automatic logic [31:0] iWord(mips_pkg::opcodeT op, logic [4:0] rs,
                                         logic [4:0] rt, logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic void emit(logic [31:0] word);
      prog.push_back(word);
   endfunction

   function automatic void loadConst(logic [4:0] rd, logic [31:0] value);
      emit(iWord(mips_pkg::OpLui, 5'd0, rd, value[31:16]));
      emit(iWord(mips_pkg::OpOri, rd, rd, value[15:0]));
   endfunction

   // Store to the next result slot that must appear
   function automatic void checkedStore(logic [4:0] rt, logic [31:0] value);
      emit(iWord(mips_pkg::OpSw, 5'd0, rt, 16'(resultPtr)));
      expAddr.push_back(32'(resultPtr));
      expData.push_back(value);
      resultPtr += 4;
   endfunction

   // Store to the next result slot on a path that is jumped over
   function automatic void guardedStore(logic [4:0] rt);
      emit(iWord(mips_pkg::OpSw, 5'd0, rt, 16'(resultPtr)));
      resultPtr += 4;
   endfunction

   // ==================================================
   // Expected results from the instruction rules
   // ==================================================
   function automatic logic [31:0] rRule(mips_pkg::functT fn, logic [31:0] a, logic [31:0] b);
      case (fn)
         mips_pkg::FnAdd, mips_pkg::FnAddu: return a + b;
         mips_pkg::FnSub, mips_pkg::FnSubu: return a - b;
         mips_pkg::FnAnd: return a & b;
         mips_pkg::FnOr:  return a | b;
         mips_pkg::FnXor: return a ^ b;
         mips_pkg::FnNor: return ~(a | b);
         mips_pkg::FnSlt: return {31'd0, $signed(a) < $signed(b)};
         default:         return {31'd0, a < b};
      endcase
   endfunction

   function automatic logic [31:0] iRule(mips_pkg::opcodeT op, logic [31:0] a,
                                         logic [15:0] imm);
      logic [31:0] sext, zext;
      sext = {{16{imm[15]}}, imm};
      zext = {16'h0000, imm};
      case (op)
         mips_pkg::OpAddi, mips_pkg::OpAddiu: return a + sext;
         mips_pkg::OpSlti:  return {31'd0, $signed(a) < $signed(sext)};
         mips_pkg::OpSltiu: return {31'd0, a < sext};
         mips_pkg::OpAndi:  return a & zext;
         mips_pkg::OpOri:   return a | zext;
         mips_pkg::OpXori:  return a ^ zext;
         default:           return {imm, 16'h0000};   // lui
      endcase
   endfunction

   // ==================================================
   // Program and expected-store tables
   // ==================================================
   function automatic void buildProgram();
      mips_pkg::functT rOps[12] = '{
         mips_pkg::FnAdd, mips_pkg::FnAddu, mips_pkg::FnSub, mips_pkg::FnSubu,
         mips_pkg::FnAnd, mips_pkg::FnOr, mips_pkg::FnXor, mips_pkg::FnNor,
         mips_pkg::FnSlt, mips_pkg::FnSltu, mips_pkg::FnSlt, mips_pkg::FnSltu};
      mips_pkg::opcodeT iOps[8] = '{
         mips_pkg::OpAddi, mips_pkg::OpAddiu, mips_pkg::OpSlti, mips_pkg::OpSltiu,
         mips_pkg::OpAndi, mips_pkg::OpOri, mips_pkg::OpXori, mips_pkg::OpLui};
      logic [15:0] iImm[8] = '{16'hFFF0, 16'h8001, 16'hFFFF, 16'h8000,
                               16'h8005, 16'h8000, 16'hFFFF, 16'hABCD};
      logic [4:0] iSrc[8] = '{5'd1, 5'd1, 5'd0, 5'd2, 5'd1, 5'd1, 5'd2, 5'd0};
      mips_pkg::opcodeT brOps[4] = '{
         mips_pkg::OpBeq, mips_pkg::OpBeq, mips_pkg::OpBne, mips_pkg::OpBne};
      logic [4:0]  brRs[4] = '{5'd1, 5'd1, 5'd1, 5'd2};
      logic [4:0]  brRt[4] = '{5'd2, 5'd1, 5'd2, 5'd2};
      logic [31:0] regVal[3] = '{32'h0, OpndA, OpndB};
      logic [4:0]  rs, rt;
      logic [63:0] product;
      logic        taken;
      int          jumpAt;

      resultPtr = ResultBase;
      loadConst(5'd1, OpndA);
      loadConst(5'd2, OpndB);
      for (int k = 0; k < 12; k++) begin
         rs = (k < 10) ? 5'd1 : 5'd2;   // Last two rows swap the compare
         rt = (k < 10) ? 5'd2 : 5'd1;
         emit(rWord(rs, rt, 5'd3, rOps[k]));
         checkedStore(5'd3, rRule(rOps[k], regVal[rs], regVal[rt]));
      end
      for (int k = 0; k < 8; k++) begin
         emit(iWord(iOps[k], iSrc[k], 5'd4, iImm[k]));
         checkedStore(5'd4, iRule(iOps[k], regVal[iSrc[k]], iImm[k]));
      end
      emit(iWord(mips_pkg::OpAddi, 5'd1, 5'd0, 16'h1234));   // r0 stays zero
      emit(iWord(mips_pkg::OpLui, 5'd0, 5'd0, 16'hBEEF));
      checkedStore(5'd0, 32'h0);

      // Loads at base + 8 and stores back at base - 0x100
      emit(iWord(mips_pkg::OpOri, 5'd0, 5'd5, 16'(DataBase)));
      for (int k = 0; k < NumWords; k++) begin
         emit(iWord(mips_pkg::OpLw, 5'd5, 5'd6, 16'(8 + 4 * k)));
         emit(iWord(mips_pkg::OpSw, 5'd5, 5'd6, 16'(16'hFF00 + 4 * k)));
         expAddr.push_back(32'(DataBase - 'h100 + 4 * k));
         expData.push_back(dataWords[k]);
      end

      for (int k = 0; k < NumMults; k++) begin
         product = {32'h0, multA[k]} * {32'h0, multB[k]};
         emit(iWord(mips_pkg::OpLw, 5'd5, 5'd10, 16'('h40 + 8 * k)));
         emit(iWord(mips_pkg::OpLw, 5'd5, 5'd11, 16'('h44 + 8 * k)));
         emit(rWord(5'd10, 5'd11, 5'd0, mips_pkg::FnMultu));
         emit(rWord(5'd0, 5'd0, 5'd12, mips_pkg::FnMflo));
         checkedStore(5'd12, product[31:0]);
         emit(rWord(5'd0, 5'd0, 5'd13, mips_pkg::FnMfhi));
         checkedStore(5'd13, product[63:32]);
      end

      // Each branch skips one store of the fall-through marker in r8
      emit(iWord(mips_pkg::OpOri, 5'd0, 5'd8, 16'hFA11));
      for (int k = 0; k < 4; k++) begin
         taken = (brOps[k] == mips_pkg::OpBeq) == (regVal[brRs[k]] == regVal[brRt[k]]);
         emit(iWord(mips_pkg::OpOri, 5'd0, 5'd9, 16'(16'h0500 + k)));
         emit(iWord(brOps[k], brRs[k], brRt[k], 16'd1));
         if (taken)
            guardedStore(5'd8);
         else
            checkedStore(5'd8, 32'h0000_FA11);
         checkedStore(5'd9, 32'(32'h0500 + k));
      end

      emit(iWord(mips_pkg::OpOri, 5'd0, 5'd9, 16'h0600));
      jumpAt = prog.size();
      emit({mips_pkg::OpJ, 26'(jumpAt + 3)});   // Over two stores
      guardedStore(5'd8);
      guardedStore(5'd8);
      checkedStore(5'd9, 32'h0000_0600);

      emit(iWord(mips_pkg::OpOri, 5'd0, 5'd14, 16'h600D));
      emit(iWord(mips_pkg::OpSw, 5'd0, 5'd14, 16'(MarkerAddr)));
      expAddr.push_back(32'(MarkerAddr));
      expData.push_back(32'h0000_600D);
      emit({mips_pkg::OpJ, 26'(prog.size())});   // Spin
   endfunction

   // ==================================================
   // Stimulus, watchdog and checks
   // ==================================================
   initial begin
      void'($urandom(74354));
      for (int k = 0; k < NumWords; k++)
         dataWords[k] = $urandom();
      for (int k = 0; k < NumMults; k++) begin
         multA[k] = $urandom();
         multB[k] = $urandom();
      end
      multA[0] = 32'hFFFF_FFFF;   // Largest product
      multB[0] = 32'hFFFF_FFFF;
      buildProgram();

      watchdogNs = (prog.size() + 8) * 40 * 8;
      fork
         begin
            #(watchdogNs);
            $display("Timeout: no final store after %0d ns", watchdogNs);
            stopWithFailure();
         end
      join_none

      @(posedge clk);
      #1;
      foreach (prog[i])
         memory.words[i] = prog[i];
      for (int k = 0; k < NumWords; k++)
         memory.words[DataBase / 4 + 2 + k] = dataWords[k];
      for (int k = 0; k < NumMults; k++) begin
         memory.words[DataBase / 4 + 'h10 + 2 * k] = multA[k];
         memory.words[DataBase / 4 + 'h11 + 2 * k] = multB[k];
      end

      @(negedge clk);
      while (reset) begin
         assert (memRead == 1'b0) else reportMismatch("memRead", 32'(memRead), 32'h0);
         assert (memWrite == 1'b0) else reportMismatch("memWrite", 32'(memWrite), 32'h0);
         @(negedge clk);
      end
      while (memRead !== 1'b1)
         @(negedge clk);
      assert (memAddr == 32'h0) else reportMismatch("memAddr", memAddr, 32'h0);

      for (int n = 0; n < expAddr.size(); n++) begin
         do
            @(negedge clk);
         while (!storeValid);
         assert (storeAddr == expAddr[n]) else reportMismatch("memAddr", storeAddr, expAddr[n]);
         assert (storeData == expData[n])
            else reportMismatch("memWriteData", storeData, expData[n]);
      end
      $display("Test OK");
      $finish;
   end

endmodule

// File: verilog.f
+incdir+rtl
rtl/mips_pkg.sv
rtl/mipsAlu.sv
rtl/regFile.sv
rtl/multuUnit.sv
rtl/mipsControl.sv
rtl/mipsDatapath.sv
rtl/multiCycleMips.sv
verif/tbClock.sv
verif/tbMemory.sv
verif/mipsTb.sv

// File: Makefile
TOP := mipsTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f verilog.f

run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f verilog.f

clean:
	rm -rf obj_dir
